// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,
        opcOpImm  = 7'b0010011,
        opcLoad   = 7'b0000011,
        opcStore  = 7'b0100011,
        opcBranch = 7'b1100011
    } opcode_t;

    localparam logic [2:0] funct3Add = 3'b000; // ADD, SUB and ADDI
    localparam logic [2:0] funct3Xor = 3'b100;
    localparam logic [2:0] funct3Or  = 3'b110;
    localparam logic [2:0] funct3And = 3'b111;
    localparam logic [2:0] funct3Beq = 3'b000;
    localparam logic [2:0] funct3Bne = 3'b001;
    localparam logic [2:0] funct3Ld  = 3'b011; // Doubleword, shared by LD and SD

    localparam logic [6:0] funct7Sub = 7'b0100000;

    // Bit offsets of the instruction fields
    localparam int opcodeLsb = 0;
    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;
    localparam int funct7Lsb = 25;

endpackage

`default_nettype wire

// File: verilog/corePkg.sv
`default_nettype none

package corePkg;

    localparam int xlen     = 64;
    localparam int regAddrW = 5;
    localparam int instW    = 32;

    localparam logic [xlen-1:0] resetPc = 64'h0000_0000_8000_0000;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor} aluOp_t;

    // Operand source in execute
    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSel_t;

    typedef enum logic {arbFetch, arbData} arbState_t;

    // Word for instruction fetch, doubleword for LD/SD
    typedef enum logic {sizeWord, sizeDouble} accessSize_t;

endpackage

`default_nettype wire

// File: verilog/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input  logic [corePkg::instW-1:0]    inst,
    output logic [corePkg::regAddrW-1:0] rs1,
    output logic [corePkg::regAddrW-1:0] rs2,
    output logic [corePkg::regAddrW-1:0] rd,
    output logic [corePkg::xlen-1:0]     imm,
    output corePkg::aluOp_t              aluOp,
    output logic                         useImm,
    output logic                         regWrite,
    output logic                         rs1Read,
    output logic                         rs2Read,
    output logic                         isLoad,
    output logic                         isStore,
    output logic                         isBranch,
    output logic                         branchNe
);
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic [corePkg::xlen-1:0] immI;
    logic [corePkg::xlen-1:0] immS;
    logic [corePkg::xlen-1:0] immB;

    assign rs1    = inst[rvIsaPkg::rs1Lsb +: corePkg::regAddrW];
    assign rs2    = inst[rvIsaPkg::rs2Lsb +: corePkg::regAddrW];
    assign rd     = inst[rvIsaPkg::rdLsb +: corePkg::regAddrW];
    assign funct3 = inst[rvIsaPkg::funct3Lsb +: 3];
    assign funct7 = inst[rvIsaPkg::funct7Lsb +: 7];

    assign immI = {{(corePkg::xlen-12){inst[31]}}, inst[31:20]};
    assign immS = {{(corePkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(corePkg::xlen-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};

    assign branchNe = (funct3 == rvIsaPkg::funct3Bne); // Only meaningful with isBranch

    always_comb begin
        aluOp    = corePkg::aluAdd;
        imm      = immI;
        useImm   = 1'b0;
        regWrite = 1'b0;
        rs1Read  = 1'b0;
        rs2Read  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        case (rvIsaPkg::opcode_t'(inst[rvIsaPkg::opcodeLsb +: 7]))
            rvIsaPkg::opcOp: begin
                rs1Read  = 1'b1;
                rs2Read  = 1'b1;
                regWrite = 1'b1;
                case (funct3)
                    rvIsaPkg::funct3Add: aluOp = (funct7 == rvIsaPkg::funct7Sub) ?
                                                 corePkg::aluSub : corePkg::aluAdd;
                    rvIsaPkg::funct3Xor: aluOp = corePkg::aluXor;
                    rvIsaPkg::funct3Or:  aluOp = corePkg::aluOr;
                    rvIsaPkg::funct3And: aluOp = corePkg::aluAnd;
                    default:             regWrite = 1'b0; // Shifts and compares not supported
                endcase
            end
            rvIsaPkg::opcOpImm: begin // ADDI only
                rs1Read  = 1'b1;
                useImm   = 1'b1;
                regWrite = (funct3 == rvIsaPkg::funct3Add);
            end
            rvIsaPkg::opcLoad: begin
                rs1Read  = 1'b1;
                useImm   = 1'b1;
                isLoad   = (funct3 == rvIsaPkg::funct3Ld);
                regWrite = isLoad;
            end
            rvIsaPkg::opcStore: begin
                rs1Read = 1'b1;
                rs2Read = 1'b1;
                useImm  = 1'b1;
                imm     = immS;
                isStore = (funct3 == rvIsaPkg::funct3Ld);
            end
            rvIsaPkg::opcBranch: begin
                rs1Read  = 1'b1;
                rs2Read  = 1'b1;
                imm      = immB;
                isBranch = (funct3 == rvIsaPkg::funct3Beq) || (funct3 == rvIsaPkg::funct3Bne);
            end
            default: ; // Unknown opcode, no side effects
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [corePkg::regAddrW-1:0] rdAddr1,
    input  logic [corePkg::regAddrW-1:0] rdAddr2,
    input  logic [corePkg::regAddrW-1:0] wrAddr,
    input  logic [corePkg::xlen-1:0]     wrData,
    input  logic                         wrEn,
    output logic [corePkg::xlen-1:0]     rdData1,
    output logic [corePkg::xlen-1:0]     rdData2
);
    logic [corePkg::xlen-1:0] regs [0:(1 << corePkg::regAddrW)-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < (1 << corePkg::regAddrW); i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-through, decode sees the value retiring this cycle
    assign rdData1 = (rdAddr1 == '0) ? '0 :
                     (wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 :
                     (wrEn && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  logic [corePkg::regAddrW-1:0] exRs1,
    input  logic [corePkg::regAddrW-1:0] exRs2,
    input  logic                         exRs1Read,
    input  logic                         exRs2Read,
    input  logic [corePkg::regAddrW-1:0] memRd,
    input  logic                         memRegWrite,
    input  logic                         memIsLoad,
    input  logic [corePkg::regAddrW-1:0] wbRd,
    input  logic                         wbRegWrite,
    input  logic [corePkg::regAddrW-1:0] idRs1,
    input  logic [corePkg::regAddrW-1:0] idRs2,
    input  logic                         idRs1Read,
    input  logic                         idRs2Read,
    input  logic [corePkg::regAddrW-1:0] exRd,
    input  logic                         exIsLoad,
    output corePkg::fwdSel_t             fwd1,
    output corePkg::fwdSel_t             fwd2,
    output logic                         loadUseStall
);
    function automatic corePkg::fwdSel_t pickSource(
        input logic [corePkg::regAddrW-1:0] rs,
        input logic                         rsRead
    );
        logic memHit;
        logic wbHit;
        memHit = rsRead && rs != '0 && memRegWrite && memRd == rs;
        wbHit  = rsRead && rs != '0 && wbRegWrite && wbRd == rs;
        if (memHit && !memIsLoad) begin
            return corePkg::fwdMem;
        end else if (wbHit && !memHit) begin // Younger producer in memory wins
            return corePkg::fwdWb;
        end
        return corePkg::fwdReg;
    endfunction

    assign fwd1 = pickSource(exRs1, exRs1Read);
    assign fwd2 = pickSource(exRs2, exRs2Read);

    // Load result exists only after the memory stage, one bubble needed
    assign loadUseStall = exIsLoad && exRd != '0 &&
                          ((idRs1Read && idRs1 == exRd) || (idRs2Read && idRs2 == exRd));

endmodule

`default_nettype wire

// File: verilog/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic [corePkg::xlen-1:0] rs1Data,
    input  logic [corePkg::xlen-1:0] rs2Data,
    input  logic [corePkg::xlen-1:0] memFwdData,
    input  logic [corePkg::xlen-1:0] wbFwdData,
    input  corePkg::fwdSel_t         fwd1,
    input  corePkg::fwdSel_t         fwd2,
    input  logic [corePkg::xlen-1:0] imm,
    input  logic [corePkg::xlen-1:0] pc,
    input  corePkg::aluOp_t          aluOp,
    input  logic                     useImm,
    input  logic                     isBranch,
    input  logic                     branchNe,
    output logic [corePkg::xlen-1:0] aluResult,
    output logic [corePkg::xlen-1:0] storeData,
    output logic                     branchTaken,
    output logic [corePkg::xlen-1:0] branchTarget
);
    logic [corePkg::xlen-1:0] opA;
    logic [corePkg::xlen-1:0] opB;

    function automatic logic [corePkg::xlen-1:0] pickOperand(
        input corePkg::fwdSel_t         sel,
        input logic [corePkg::xlen-1:0] regVal
    );
        case (sel)
            corePkg::fwdMem: return memFwdData;
            corePkg::fwdWb:  return wbFwdData;
            default:         return regVal;
        endcase
    endfunction

    assign opA       = pickOperand(fwd1, rs1Data);
    assign storeData = pickOperand(fwd2, rs2Data); // Also the second compare operand
    assign opB       = useImm ? imm : storeData;

    always_comb begin
        case (aluOp)
            corePkg::aluSub: aluResult = opA - opB;
            corePkg::aluAnd: aluResult = opA & opB;
            corePkg::aluOr:  aluResult = opA | opB;
            corePkg::aluXor: aluResult = opA ^ opB;
            default:         aluResult = opA + opB; // Also load/store address
        endcase
    end

    assign branchTaken  = isBranch && ((opA == storeData) != branchNe);
    assign branchTarget = pc + imm;

endmodule

`default_nettype wire

// File: verilog/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     memReady,
    input  logic [corePkg::xlen-1:0] pc,
    input  logic [corePkg::xlen-1:0] dataAddr,
    input  logic [corePkg::xlen-1:0] storeData,
    input  logic                     memLoad,
    input  logic                     memStore,
    output logic                     memRdEn,
    output logic                     memWrEn,
    output logic [corePkg::xlen-1:0] memAddr,
    output logic [corePkg::xlen-1:0] memWrData,
    output corePkg::accessSize_t     memSize,
    output logic                     fetchDone,
    output logic                     advance
);
    corePkg::arbState_t state;
    corePkg::arbState_t nextState;
    logic               inData;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= corePkg::arbFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        fetchDone = 1'b0;
        advance   = 1'b0;
        case (state)
            corePkg::arbFetch: begin
                if (memReady) begin
                    fetchDone = 1'b1;
                    if (memLoad || memStore) begin
                        nextState = corePkg::arbData; // Data access still owed
                    end else begin
                        advance = 1'b1;
                    end
                end
            end
            default: begin
                if (memReady) begin
                    advance   = 1'b1;
                    nextState = corePkg::arbFetch;
                end
            end
        endcase
    end

    assign inData    = (state == corePkg::arbData);
    assign memRdEn   = inData ? memLoad : 1'b1;
    assign memWrEn   = inData && memStore;
    assign memAddr   = inData ? dataAddr : pc;
    assign memWrData = storeData;
    assign memSize   = inData ? corePkg::sizeDouble : corePkg::sizeWord;

    assert property (@(posedge clk) disable iff (!rstn) !(memRdEn && memWrEn))
        else $error("memArbiter: read and write requested together");

    // Pipeline is frozen while memory is busy, so the request holds
    assert property (@(posedge clk) disable iff (!rstn)
                     (memRdEn || memWrEn) && !memReady |=> $stable(memAddr))
        else $error("memArbiter: address changed while request pending");

endmodule

`default_nettype wire

// File: verilog/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     memReady,
    input  logic [corePkg::xlen-1:0] memRdData,
    output logic                     memRdEn,
    output logic                     memWrEn,
    output logic [corePkg::xlen-1:0] memAddr,
    output logic [corePkg::xlen-1:0] memWrData,
    output corePkg::accessSize_t     memSize
);
    logic [corePkg::xlen-1:0]  pc;
    logic                      advance;
    logic                      fetchDone;
    logic [corePkg::instW-1:0] instHold;
    logic [corePkg::instW-1:0] ifInst;

    // Decode stage
    logic [corePkg::instW-1:0]    idInst;
    logic [corePkg::xlen-1:0]     idPc, idImm, idRs1Data, idRs2Data;
    logic [corePkg::regAddrW-1:0] idRs1, idRs2, idRd;
    corePkg::aluOp_t              idAluOp;
    logic                         idUseImm, idRegWrite, idRs1Read, idRs2Read;
    logic                         idIsLoad, idIsStore, idIsBranch, idBranchNe;

    // Execute stage
    logic [corePkg::xlen-1:0]     exPc, exImm, exRs1Data, exRs2Data;
    logic [corePkg::regAddrW-1:0] exRs1, exRs2, exRd;
    corePkg::aluOp_t              exAluOp;
    logic                         exUseImm, exBranchNe, exRegWrite, exRs1Read, exRs2Read;
    logic                         exIsLoad, exIsStore, exIsBranch;
    logic [corePkg::xlen-1:0]     aluResult, storeData, branchTarget;
    logic                         branchTaken, loadUseStall, flushEx;
    corePkg::fwdSel_t             fwd1, fwd2;

    // Memory and writeback stages
    logic [corePkg::xlen-1:0]     memAlu, memStoreData, wbAlu, wbLoadData, wbData;
    logic [corePkg::regAddrW-1:0] memRd, wbRd;
    logic                         memRegWrite, memIsLoad, memIsStore, wbRegWrite, wbIsLoad;

    // Word arrives early when a data access follows in the same step
    assign ifInst  = fetchDone ? memRdData[corePkg::instW-1:0] : instHold;
    assign flushEx = loadUseStall || branchTaken;
    assign wbData  = wbIsLoad ? wbLoadData : wbAlu;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pc          <= corePkg::resetPc;
            idInst      <= '0;
            exRegWrite  <= 1'b0;
            exRs1Read   <= 1'b0;
            exRs2Read   <= 1'b0;
            exIsLoad    <= 1'b0;
            exIsStore   <= 1'b0;
            exIsBranch  <= 1'b0;
            memRegWrite <= 1'b0;
            memIsLoad   <= 1'b0;
            memIsStore  <= 1'b0;
            wbRegWrite  <= 1'b0;
            wbIsLoad    <= 1'b0;
        end else if (advance) begin
            if (branchTaken) begin
                pc     <= branchTarget;
                idInst <= '0; // Zero word decodes to a bubble
            end else if (!loadUseStall) begin
                pc     <= pc + 64'd4;
                idInst <= ifInst;
            end
            exRegWrite  <= idRegWrite && !flushEx;
            exRs1Read   <= idRs1Read && !flushEx;
            exRs2Read   <= idRs2Read && !flushEx;
            exIsLoad    <= idIsLoad && !flushEx;
            exIsStore   <= idIsStore && !flushEx;
            exIsBranch  <= idIsBranch && !flushEx;
            memRegWrite <= exRegWrite;
            memIsLoad   <= exIsLoad;
            memIsStore  <= exIsStore;
            wbRegWrite  <= memRegWrite;
            wbIsLoad    <= memIsLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instHold <= memRdData[corePkg::instW-1:0];
        end
        if (advance) begin
            if (!loadUseStall) begin
                idPc <= pc;
            end
            exPc         <= idPc;
            exImm        <= idImm;
            exRs1Data    <= idRs1Data;
            exRs2Data    <= idRs2Data;
            exRs1        <= idRs1;
            exRs2        <= idRs2;
            exRd         <= idRd;
            exAluOp      <= idAluOp;
            exUseImm     <= idUseImm;
            exBranchNe   <= idBranchNe;
            memAlu       <= aluResult;
            memStoreData <= storeData;
            memRd        <= exRd;
            wbAlu        <= memAlu;
            wbLoadData   <= memRdData; // Valid here when a load completes
            wbRd         <= memRd;
        end
    end

    memArbiter u_memArbiter (
        .clk(clk), .rstn(rstn), .memReady(memReady), .pc(pc),
        .dataAddr(memAlu), .storeData(memStoreData),
        .memLoad(memIsLoad), .memStore(memIsStore),
        .memRdEn(memRdEn), .memWrEn(memWrEn), .memAddr(memAddr),
        .memWrData(memWrData), .memSize(memSize),
        .fetchDone(fetchDone), .advance(advance)
    );

    instDecoder u_instDecoder (
        .inst(idInst), .rs1(idRs1), .rs2(idRs2), .rd(idRd), .imm(idImm),
        .aluOp(idAluOp), .useImm(idUseImm), .regWrite(idRegWrite),
        .rs1Read(idRs1Read), .rs2Read(idRs2Read), .isLoad(idIsLoad),
        .isStore(idIsStore), .isBranch(idIsBranch), .branchNe(idBranchNe)
    );

    regFile u_regFile (
        .clk(clk), .rstn(rstn), .rdAddr1(idRs1), .rdAddr2(idRs2),
        .wrAddr(wbRd), .wrData(wbData), .wrEn(wbRegWrite),
        .rdData1(idRs1Data), .rdData2(idRs2Data)
    );

    hazardUnit u_hazardUnit (
        .exRs1(exRs1), .exRs2(exRs2), .exRs1Read(exRs1Read), .exRs2Read(exRs2Read),
        .memRd(memRd), .memRegWrite(memRegWrite), .memIsLoad(memIsLoad),
        .wbRd(wbRd), .wbRegWrite(wbRegWrite),
        .idRs1(idRs1), .idRs2(idRs2), .idRs1Read(idRs1Read), .idRs2Read(idRs2Read),
        .exRd(exRd), .exIsLoad(exIsLoad),
        .fwd1(fwd1), .fwd2(fwd2), .loadUseStall(loadUseStall)
    );

    execUnit u_execUnit (
        .rs1Data(exRs1Data), .rs2Data(exRs2Data),
        .memFwdData(memAlu), .wbFwdData(wbData), .fwd1(fwd1), .fwd2(fwd2),
        .imm(exImm), .pc(exPc), .aluOp(exAluOp), .useImm(exUseImm),
        .isBranch(exIsBranch), .branchNe(exBranchNe),
        .aluResult(aluResult), .storeData(storeData),
        .branchTaken(branchTaken), .branchTarget(branchTarget)
    );

endmodule

`default_nettype wire

// File: sim/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriod  = 10,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1; // Released away from the active edge
    end

endmodule

`default_nettype wire

// File: sim/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel #(
    parameter int memWords = 512
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     memRdEn,
    input  logic                     memWrEn,
    input  logic [corePkg::xlen-1:0] memAddr,
    input  logic [corePkg::xlen-1:0] memWrData,
    input  corePkg::accessSize_t     memSize,
    input  logic [corePkg::xlen-1:0] image [0:memWords-1],
    output logic                     memReady,
    output logic [corePkg::xlen-1:0] memRdData
);
    logic [corePkg::xlen-1:0] mem [0:memWords-1];
    logic                     busy;
    int                       waitLeft;
    logic                     pendWr;
    logic [corePkg::xlen-1:0] pendAddr;
    logic [corePkg::xlen-1:0] pendData;

    function automatic int wordIndex(input logic [corePkg::xlen-1:0] addr);
        return int'((addr - corePkg::resetPc) >> 3) % memWords;
    endfunction

    function automatic logic [corePkg::xlen-1:0] readData(
        input logic [corePkg::xlen-1:0] addr,
        input corePkg::accessSize_t     size
    );
        logic [corePkg::xlen-1:0] d;
        d = mem[wordIndex(addr)];
        if (size == corePkg::sizeWord) begin
            return {32'd0, addr[2] ? d[63:32] : d[31:0]}; // Upper or lower instruction
        end
        return d;
    endfunction

    initial begin
        void'($urandom(45));
        memReady  = 1'b0;
        memRdData = '0;
        busy      = 1'b0;
        waitLeft  = 0;
        pendWr    = 1'b0;
        pendAddr  = '0;
        pendData  = '0;
    end

    always @(negedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] = image[i];
            end
            memReady = 1'b0;
            busy     = 1'b0;
        end else begin
            if (memReady) begin // Transfer finished at the last rising edge
                if (pendWr) begin
                    mem[wordIndex(pendAddr)] = pendData;
                end
                memReady = 1'b0;
                busy     = 1'b0;
            end
            if (!busy && (memRdEn || memWrEn)) begin
                busy     = 1'b1;
                waitLeft = int'($urandom % 4); // 0 to 3 wait cycles
            end
            if (busy) begin
                if (waitLeft == 0) begin
                    memReady  = 1'b1;
                    memRdData = readData(memAddr, memSize);
                    pendWr    = memWrEn;
                    pendAddr  = memAddr;
                    pendData  = memWrData;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tbCpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuCore;
    localparam int memWords = 512;
    localparam int rows     = 8;

    logic                     clk;
    logic                     rstn;
    logic                     memReady;
    logic                     memRdEn;
    logic                     memWrEn;
    logic [corePkg::xlen-1:0] memRdData;
    logic [corePkg::xlen-1:0] memAddr;
    logic [corePkg::xlen-1:0] memWrData;
    corePkg::accessSize_t     memSize;
    logic [corePkg::xlen-1:0] memImage [0:memWords-1];

    logic [corePkg::xlen-1:0] tableA [0:rows-1];
    logic [corePkg::xlen-1:0] tableB [0:rows-1];
    logic [corePkg::xlen-1:0] seenAddr [$];
    logic [corePkg::xlen-1:0] seenData [$];
    corePkg::accessSize_t     seenSize [$];
    logic                     seenRdEn [$];
    logic [31:0]              prog [$];

    clockGen #(.halfPeriod(10), .resetCycles(5)) u_clockGen (.clk(clk), .rstn(rstn));

    memModel #(.memWords(memWords)) u_memModel (
        .clk(clk), .rstn(rstn), .memRdEn(memRdEn), .memWrEn(memWrEn),
        .memAddr(memAddr), .memWrData(memWrData), .memSize(memSize),
        .image(memImage), .memReady(memReady), .memRdData(memRdData)
    );

    cpuCore i_dut (
        .clk(clk), .rstn(rstn), .memReady(memReady), .memRdData(memRdData),
        .memRdEn(memRdEn), .memWrEn(memWrEn), .memAddr(memAddr),
        .memWrData(memWrData), .memSize(memSize)
    );

    // Every completed write at the port, in order
    always @(posedge clk) begin
        if (rstn && memWrEn && memReady) begin
            seenAddr.push_back(memAddr);
            seenData.push_back(memWrData);
            seenSize.push_back(memSize);
            seenRdEn.push_back(memRdEn);
        end
    end

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rvIsaPkg::opcOp};
    endfunction

    function automatic logic [31:0] encI(input rvIsaPkg::opcode_t op, input logic [2:0] f3,
                                         input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] encS(input int rs2, input int rs1, input int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), rvIsaPkg::funct3Ld, i[4:0], rvIsaPkg::opcStore};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int imm);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], rvIsaPkg::opcBranch};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return encI(rvIsaPkg::opcOpImm, rvIsaPkg::funct3Add, rd, rs1, imm);
    endfunction

    task automatic stopRun();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkAddr(input logic [corePkg::xlen-1:0] got,
                             input logic [corePkg::xlen-1:0] exp, input int n);
        if (got !== exp) begin
            $display("FAILED at %0t: store %0d address %h, expected %h", $time, n, got, exp);
            stopRun();
        end
    endtask

    task automatic checkData(input logic [corePkg::xlen-1:0] got,
                             input logic [corePkg::xlen-1:0] exp, input int n);
        if (got !== exp) begin
            $display("FAILED at %0t: store %0d data %h, expected %h", $time, n, got, exp);
            stopRun();
        end
    endtask

    task automatic checkSize(input corePkg::accessSize_t got,
                             input corePkg::accessSize_t exp, input int n);
        if (got !== exp) begin
            $display("FAILED at %0t: store %0d size %s, expected %s", $time, n,
                     got.name(), exp.name());
            stopRun();
        end
    endtask

    task automatic checkRdEn(input logic got, input logic exp, input int n);
        if (got !== exp) begin
            $display("FAILED at %0t: store %0d read enable %b, expected %b", $time, n, got, exp);
            stopRun();
        end
    endtask

    task automatic waitStore(input int n);
        for (int c = 0; c < 3000 && seenAddr.size() == 0; c++) begin
            @(negedge clk);
        end
        if (seenAddr.size() == 0) begin
            $display("No store arrived in time, waiting for store %0d", n);
            stopRun();
        end
    endtask

    task automatic buildProgram();
        prog.push_back(addi(1, 0, 1));
        prog.push_back(addi(5, 0, 31));
        prog.push_back(encR(7'd0, rvIsaPkg::funct3Add, 1, 1, 1)); // Doubling to 2**31
        prog.push_back(addi(5, 5, -1));
        prog.push_back(encB(rvIsaPkg::funct3Bne, 5, 0, -8));
        prog.push_back(addi(2, 1, 'h500)); // Output slots
        prog.push_back(addi(1, 1, 'h400)); // Operand table
        prog.push_back(addi(3, 0, rows));
        prog.push_back(addi(16, 0, 1));
        prog.push_back(encI(rvIsaPkg::opcLoad, rvIsaPkg::funct3Ld, 10, 1, 0)); // Loop head
        prog.push_back(encI(rvIsaPkg::opcLoad, rvIsaPkg::funct3Ld, 11, 1, 8));
        prog.push_back(encR(7'd0, rvIsaPkg::funct3Add, 12, 10, 11)); // Load-use
        prog.push_back(encR(rvIsaPkg::funct7Sub, rvIsaPkg::funct3Add, 13, 10, 11));
        prog.push_back(encR(7'd0, rvIsaPkg::funct3Xor, 14, 10, 11));
        prog.push_back(encR(7'd0, rvIsaPkg::funct3And, 15, 10, 11));
        prog.push_back(encR(7'd0, rvIsaPkg::funct3Or, 15, 15, 16));
        prog.push_back(addi(17, 10, 12));
        prog.push_back(addi(18, 0, 0));
        prog.push_back(encB(rvIsaPkg::funct3Beq, 10, 11, 8)); // Skips the flag set
        prog.push_back(addi(18, 0, 1));
        prog.push_back(encS(12, 2, 0));
        prog.push_back(encS(13, 2, 8));
        prog.push_back(encS(14, 2, 16));
        prog.push_back(encS(15, 2, 24));
        prog.push_back(encS(17, 2, 32));
        prog.push_back(encS(18, 2, 40));
        prog.push_back(addi(1, 1, 16));
        prog.push_back(addi(2, 2, 48));
        prog.push_back(addi(3, 3, -1));
        prog.push_back(encB(rvIsaPkg::funct3Bne, 3, 0, -80));
        prog.push_back(encB(rvIsaPkg::funct3Beq, 0, 0, 0)); // Parks here
    endtask

    initial begin
        logic [corePkg::xlen-1:0] a;
        logic [corePkg::xlen-1:0] b;
        logic [corePkg::xlen-1:0] expAddr;
        logic [corePkg::xlen-1:0] expData [0:5];
        int                       n;

        tableA = '{64'd5, 64'd7, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1234_5678_9ABC_DEF0,
                   64'd0, 64'h8000_0000_0000_0000, 64'h0F0F_0F0F_0F0F_0F0F, 64'd100};
        tableB = '{64'd5, 64'd3, 64'd1, 64'h1234_5678_9ABC_DEF0,
                   64'd0, 64'h7FFF_FFFF_FFFF_FFFF, 64'hF0F0_F0F0_F0F0_F0F0, 64'd250};
        for (int i = 0; i < memWords; i++) begin
            memImage[i] = '0;
        end
        buildProgram();
        for (int i = 0; i < prog.size(); i++) begin
            if (i % 2 == 1) begin
                memImage[i / 2][63:32] = prog[i];
            end else begin
                memImage[i / 2][31:0] = prog[i];
            end
        end
        for (int r = 0; r < rows; r++) begin
            memImage['h400 / 8 + 2 * r]     = tableA[r];
            memImage['h400 / 8 + 2 * r + 1] = tableB[r];
        end

        for (int c = 0; c < 20 && !rstn; c++) begin
            @(negedge clk);
        end
        if (!rstn) begin
            $display("Reset was never released");
            stopRun();
        end

        n = 0;
        for (int r = 0; r < rows; r++) begin
            a = tableA[r];
            b = tableB[r];
            expData[0] = a + b;
            expData[1] = a - b;
            expData[2] = a ^ b;
            expData[3] = (a & b) | 64'd1;
            expData[4] = a + 64'd12;
            expData[5] = (a != b) ? 64'd1 : 64'd0;
            for (int j = 0; j < 6; j++) begin
                expAddr = corePkg::resetPc + 64'h500 + 64'(48 * r) + 64'(8 * j);
                waitStore(n);
                checkAddr(seenAddr.pop_front(), expAddr, n);
                checkData(seenData.pop_front(), expData[j], n);
                checkSize(seenSize.pop_front(), corePkg::sizeDouble, n);
                checkRdEn(seenRdEn.pop_front(), 1'b0, n);
                n++;
            end
        end

        // The parked core must not write again
        for (int c = 0; c < 300; c++) begin
            @(negedge clk);
        end
        if (seenAddr.size() != 0) begin
            $display("FAILED at %0t: unexpected store to %h", $time, seenAddr[0]);
            stopRun();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
verilog/rvIsaPkg.sv
verilog/corePkg.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/execUnit.sv
verilog/memArbiter.sv
verilog/cpuCore.sv
sim/clockGen.sv
sim/memModel.sv
sim/tbCpuCore.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module tbCpuCore --Mdir obj_dir -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -qF "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
